/* all.f */
+incdir+include
src/oo_backend_pkg.sv
src/prf.sv
src/operand_stage.sv
src/retire_report.sv
src/oo_backend.sv
dv/tb_oo_backend.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_oo_backend
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv dv/*.sv include/*.svh)

.PHONY: run clean

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* include/backend_vectors.svh */
//////////////////////////////////////////////////////////////////////
// One row per clock, and each ex expectation sits in the row after its issue
// Needs the lane helpers and add_row of the including testbench
//////////////////////////////////////////////////////////////////////

localparam logic [data_width-1:0] val_a = 64'h1111_2222_3333_4444;
localparam logic [data_width-1:0] val_b = 64'h5555_6666_7777_8888;
localparam logic [data_width-1:0] val_c = 64'h0123_4567_89ab_cdef;
localparam logic [data_width-1:0] val_d = 64'hfedc_ba98_7654_3210;
localparam logic [data_width-1:0] val_e = 64'h0000_0000_dead_beef;
localparam logic [data_width-1:0] val_f = 64'h0000_0000_feed_f00d;
localparam logic [data_width-1:0] val_g = 64'ha5a5_a5a5_a5a5_a5a5;
localparam logic [data_width-1:0] val_h = 64'h5a5a_5a5a_5a5a_5a5a;
localparam logic [data_width-1:0] val_i = 64'h8000_0000_0000_0001;

// Columns: test, flush, cdb x2, issue x2, retire x2, ex x2, commit x2, count, status
task automatic load_vectors();
  // Reset state, then an issue removed by flush
  add_row(1, 0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, 0, no_error);
  add_row(1, 0, '0, '0, issued(1, 2, 3, 1, 1), '0, '0, '0,
          '0, '0, '0, '0, 0, no_error);
  add_row(1, 1, '0, '0, '0, issued(3, 4, 5, 2, 2), '0, '0,
          captured(0, 0, 3, 1, 1), '0, '0, '0, 0, no_error);
  add_row(1, 0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, 0, no_error);  // Both slots empty

  // Write two tags, read them back on both lanes
  add_row(2, 0, broadcast(5, val_a), broadcast(9, val_b), '0, '0, '0, '0,
          '0, '0, '0, '0, 0, no_error);
  add_row(2, 0, '0, '0, issued(5, 9, 10, 3, 4), issued(9, 5, 11, 7, 5), '0, '0,
          '0, '0, '0, '0, 0, no_error);
  add_row(2, 0, '0, '0, '0, '0, '0, '0,
          captured(val_a, val_b, 10, 3, 4), captured(val_b, val_a, 11, 7, 5),
          '0, '0, 0, no_error);

  // Bypass in the same cycle
  add_row(3, 0, broadcast(12, val_c), broadcast(13, val_d),
          issued(12, 13, 14, 2, 6), issued(5, 12, 15, 4, 7), '0, '0,
          '0, '0, '0, '0, 0, no_error);
  add_row(3, 0, broadcast(20, val_e), broadcast(20, val_f),
          issued(20, 13, 21, 8, 8), '0, '0, '0,
          captured(val_c, val_d, 14, 2, 6), captured(val_a, val_c, 15, 4, 7),
          '0, '0, 0, no_error);
  add_row(3, 0, '0, '0, issued(20, 20, 22, 9, 9), '0, '0, '0,
          captured(val_e, val_d, 21, 8, 8), '0, '0, '0, 0, no_error);  // Lane 0 bypass
  add_row(3, 0, '0, '0, '0, '0, '0, '0,
          captured(val_f, val_f, 22, 9, 9), '0, '0, '0, 0, no_error);  // File kept lane 1

  // Zero register
  add_row(4, 0, broadcast(0, val_g), broadcast(0, val_h),
          issued(0, 5, 23, 10, 10), issued(5, 0, 25, 12, 12), '0, '0,
          '0, '0, '0, '0, 0, no_error);
  add_row(4, 0, '0, '0, issued(0, 0, 24, 11, 11), '0, retiring(1, 0, 'h13, 7, 0), '0,
          captured(0, val_a, 23, 10, 10), captured(val_a, 0, 25, 12, 12),
          committed(0, 7, 0), '0, 1, no_error);
  add_row(4, 0, '0, '0, '0, '0, '0, '0,
          captured(0, 0, 24, 11, 11), '0, '0, '0, 0, no_error);

  // Commit report
  add_row(5, 0, '0, '0, '0, '0, retiring(1, 0, 'h33, 3, 5), retiring(1, 0, 'h33, 4, 20),
          '0, '0, committed(1, 3, val_a), committed(1, 4, val_f), 2, no_error);
  add_row(5, 0, broadcast(9, val_i), '0, '0, '0,
          retiring(1, 0, 'h33, 8, 9), retiring(0, 0, 'h33, 2, 12),
          '0, '0, committed(1, 8, val_b), committed(0, 2, val_c), 1, no_error);
  add_row(5, 0, '0, '0, '0, '0, retiring(1, 0, 'h33, 8, 9), retiring(1, 0, 'h33, 6, 0),
          '0, '0, committed(1, 8, val_i), committed(0, 6, 0), 2, no_error);

  // Count and status priority
  add_row(6, 0, '0, '0, '0, '0, retiring(1, 0, 'h13, 1, 5), retiring(1, 0, 'h13, 2, 12),
          '0, '0, committed(1, 1, val_a), committed(1, 2, val_c), 2, no_error);
  add_row(6, 0, '0, '0, '0, '0, retiring(1, 0, 'h13, 1, 5), retiring(1, 1, 'h13, 2, 12),
          '0, '0, committed(1, 1, val_a), committed(1, 2, val_c), 1, halted_on_illegal);
  add_row(6, 0, '0, '0, '0, '0, retiring(1, 1, 'h13, 1, 5), retiring(1, 0, 'h13, 2, 12),
          '0, '0, committed(1, 1, val_a), committed(1, 2, val_c), 0, halted_on_illegal);
  add_row(6, 0, '0, '0, '0, '0, retiring(1, 0, 'h555, 0, 0), '0,
          '0, '0, committed(0, 0, 0), '0, 1, halted_on_halt);
  add_row(6, 0, '0, '0, '0, '0, retiring(1, 1, 'h13, 1, 5), retiring(1, 0, 'h555, 0, 0),
          '0, '0, committed(1, 1, val_a), committed(0, 0, 0), 0, halted_on_illegal);
endtask

/* dv/tb_oo_backend.sv */
//////////////////////////////////////////////////////////////////////
// Table-driven, inputs 5 ns after the edge, ex checked 1 ns after it
// Commit outputs and status are checked 6 ns before the next edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_oo_backend
  import oo_backend_pkg::*;
();

  localparam int reset_cycles = 10;

  typedef struct packed {
    int                              test;
    logic                            flush;
    cdb_lane_t    [lane_count-1:0]   cdb;
    issue_lane_t  [lane_count-1:0]   issue;
    retire_lane_t [lane_count-1:0]   retire;
    ex_lane_t     [lane_count-1:0]   exp_ex;
    commit_lane_t [lane_count-1:0]   exp_commit;
    logic [3:0]                      exp_count;
    err_status_t                     exp_status;
  } vec_row_t;

  logic         clock;
  logic         rst_n;
  logic         flush;
  cdb_lane_t    cdb    [lane_count];
  issue_lane_t  issue  [lane_count];
  retire_lane_t retire [lane_count];
  ex_lane_t     ex     [lane_count];
  commit_lane_t commit [lane_count];
  logic [3:0]   completed_insts;
  err_status_t  error_status;

  vec_row_t vectors [$];
  int       cycle_limit  = 0;
  int       cycles       = 0;
  int       test_errors  = 0;
  int       tests_passed = 0;
  int       tests_failed = 0;
  string    test_names [6] = '{"reset and flush", "write then read", "cdb bypass",
                               "zero register", "commit report", "count and status"};

  oo_backend i_oo_backend (.clock, .rst_n, .flush, .cdb, .issue, .retire, .ex, .commit,
                           .completed_insts, .error_status);

  //////////////////////////////////////////////////////////////////////
  // Lane builders for the table

  function automatic cdb_lane_t broadcast(input int tag, input logic [data_width-1:0] value);
    cdb_lane_t lane;
    lane.valid = 1'b1;
    lane.tag   = preg_idx_width'(tag);
    lane.value = value;
    return lane;
  endfunction

  function automatic issue_lane_t issued(input int a, input int b, input int d,
                                         input int func, input int rob);
    issue_lane_t lane;
    lane = '{1'b1, preg_idx_width'(a), preg_idx_width'(b), preg_idx_width'(d),
             alu_func_width'(func), rob_idx_width'(rob)};
    return lane;
  endfunction

  function automatic retire_lane_t retiring(input int valid, input int illegal, input int ir,
                                            input int adest, input int pdest);
    retire_lane_t lane;
    lane = '{1'(valid), 1'(illegal), ir_width'(ir), arch_idx_width'(adest),
             preg_idx_width'(pdest)};
    return lane;
  endfunction

  function automatic ex_lane_t captured(input logic [data_width-1:0] opa,
                                        input logic [data_width-1:0] opb,
                                        input int d, input int func, input int rob);
    ex_lane_t lane;
    lane = '{1'b1, opa, opb, preg_idx_width'(d), alu_func_width'(func), rob_idx_width'(rob)};
    return lane;
  endfunction

  function automatic commit_lane_t committed(input int en, input int idx,
                                             input logic [data_width-1:0] data);
    commit_lane_t lane;
    lane = '{1'(en), arch_idx_width'(idx), data};
    return lane;
  endfunction

  task automatic add_row(input int test, input int fl, input cdb_lane_t c0, input cdb_lane_t c1,
                         input issue_lane_t i0, input issue_lane_t i1,
                         input retire_lane_t r0, input retire_lane_t r1,
                         input ex_lane_t x0, input ex_lane_t x1,
                         input commit_lane_t w0, input commit_lane_t w1,
                         input int count, input err_status_t status);
    vec_row_t row;
    row = '{test, 1'(fl), {c1, c0}, {i1, i0}, {r1, r0}, {x1, x0}, {w1, w0}, 4'(count), status};
    vectors.push_back(row);
  endtask

  `include "backend_vectors.svh"

  //////////////////////////////////////////////////////////////////////
  // Drive and check

  task automatic apply_inputs(input vec_row_t row);
    flush = row.flush;
    for (int l = 0; l < lane_count; l++)
    begin
      cdb[l]    = row.cdb[l];
      issue[l]  = row.issue[l];
      retire[l] = row.retire[l];
    end
  endtask

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] expected);
    assert (got === expected)
    else
    begin
      $display("error: %s got %0h expected %0h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic check_ex(input vec_row_t row);
    for (int l = 0; l < lane_count; l++)
      check_value($sformatf("ex[%0d]", l), 160'(ex[l]), 160'(row.exp_ex[l]));
  endtask

  task automatic check_retire_outputs(input vec_row_t row);
    for (int l = 0; l < lane_count; l++)
      check_value($sformatf("commit[%0d]", l), 160'(commit[l]), 160'(row.exp_commit[l]));
    check_value("completed_insts", 160'(completed_insts), 160'(row.exp_count));
    check_value("error_status", 160'(error_status), 160'(row.exp_status));
  endtask

  task automatic report_test(input int test);
    if (test_errors == 0)
    begin
      $display("test %0d %s: ok", test, test_names[test-1]);
      tests_passed++;
    end
    else
    begin
      $display("test %0d %s: %0d errors", test, test_names[test-1], test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Watchdog over the whole table
  initial
  begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit)
    begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    rst_n = 1'b0;
    flush = 1'b0;
    for (int l = 0; l < lane_count; l++)
    begin
      cdb[l]    = '0;
      issue[l]  = issued(1, 2, 3, 1, 1);  // Valid issue held off by reset
      retire[l] = '0;
    end
    load_vectors();
    cycle_limit = vectors.size() + reset_cycles + 20;
    repeat (reset_cycles) @(posedge clock);
    #1;
    for (int l = 0; l < lane_count; l++)
      check_value($sformatf("ex[%0d] in reset", l), 160'(ex[l]), '0);
    #4;
    rst_n = 1'b1;
    for (int l = 0; l < lane_count; l++)
    begin
      issue[l] = '0;
    end
    for (int k = 0; k < vectors.size(); k++)
    begin
      @(posedge clock);
      #1 check_ex(vectors[k]);  // Result of the previous row's issue
      #4 apply_inputs(vectors[k]);
      #89 check_retire_outputs(vectors[k]);
      if ((k == vectors.size() - 1) || (vectors[k+1].test != vectors[k].test))
        report_test(vectors[k].test);
    end
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* src/oo_backend.sv */
//////////////////////////////////////////////////////////////////////
// ex is one cycle behind issue; commit and status are same-cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module oo_backend
  import oo_backend_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  logic         flush,
  input  cdb_lane_t    cdb    [lane_count],
  input  issue_lane_t  issue  [lane_count],
  input  retire_lane_t retire [lane_count],
  output ex_lane_t     ex     [lane_count],
  output commit_lane_t commit [lane_count],
  output logic [3:0]   completed_insts,
  output err_status_t  error_status
);

  logic [preg_idx_width-1:0] op_idx       [2*lane_count];
  logic [data_width-1:0]     op_value     [2*lane_count];
  logic [preg_idx_width-1:0] commit_idx   [lane_count];
  logic [data_width-1:0]     commit_value [lane_count];
  logic [preg_idx_width-1:0] prf_rd_idx   [3*lane_count];
  logic [data_width-1:0]     prf_rd_data  [3*lane_count];

  // Operand ports low, commit ports above them
  always_comb
  begin
    for (int i = 0; i < 2*lane_count; i++)
    begin
      prf_rd_idx[i] = op_idx[i];
      op_value[i]   = prf_rd_data[i];
    end
    for (int l = 0; l < lane_count; l++)
    begin
      prf_rd_idx[2*lane_count+l] = commit_idx[l];
      commit_value[l]            = prf_rd_data[2*lane_count+l];
    end
  end

  prf i_prf (.clock, .rst_n, .cdb, .rd_idx(prf_rd_idx), .rd_data(prf_rd_data));

  operand_stage i_operand_stage (.clock, .rst_n, .flush, .issue, .cdb,
                                 .preg_idx(op_idx), .preg_value(op_value), .ex);

  retire_report i_retire_report (.retire, .commit_idx, .commit_value, .commit,
                                 .completed_insts, .error_status);

endmodule

/* src/retire_report.sv */
//////////////////////////////////////////////////////////////////////
// Purely combinational, reads the file before this cycle's CDB write
// Count and status logic assume exactly two retiring lanes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module retire_report
  import oo_backend_pkg::*;
(
  input  retire_lane_t              retire       [lane_count],
  output logic [preg_idx_width-1:0] commit_idx   [lane_count],
  input  logic [data_width-1:0]     commit_value [lane_count],
  output commit_lane_t              commit       [lane_count],
  output logic [3:0]                completed_insts,
  output err_status_t               error_status
);

  logic [lane_count-1:0] valid_vec;
  logic [lane_count-1:0] illegal_vec;
  logic [lane_count-1:0] halt_vec;

  //////////////////////////////////////////////////////////////////////
  // Architectural commit writes

  always_comb
  begin
    for (int l = 0; l < lane_count; l++)
    begin
      commit_idx[l]     = retire[l].pdest;
      commit[l].wr_en   = retire[l].valid && (retire[l].pdest != zero_preg);
      commit[l].wr_idx  = retire[l].adest;
      commit[l].wr_data = commit_value[l];

      valid_vec[l]   = retire[l].valid;
      illegal_vec[l] = retire[l].illegal;
      halt_vec[l]    = retire[l].valid && (retire[l].ir == halt_inst);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Completed count and halt status

  always_comb
  begin
    if (illegal_vec[0])
      completed_insts = '0;  // Nothing from this pair counts
    else if (illegal_vec[1])
      completed_insts = 4'(valid_vec[0]);
    else
      completed_insts = 4'(valid_vec[0]) + 4'(valid_vec[1]);
  end

  // Younger lane first, so the older lane overrides it
  always_comb
  begin
    error_status = no_error;
    for (int l = lane_count - 1; l >= 0; l--)
    begin
      if (halt_vec[l])
        error_status = halted_on_halt;
      else if (valid_vec[l] && illegal_vec[l])
        error_status = halted_on_illegal;
    end
  end

endmodule

/* src/operand_stage.sv */
//////////////////////////////////////////////////////////////////////
// Issue/execute register advances every cycle, no back-pressure
// Flush empties the register at the edge on which it is sampled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module operand_stage
  import oo_backend_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      flush,
  input  issue_lane_t               issue      [lane_count],
  input  cdb_lane_t                 cdb        [lane_count],
  output logic [preg_idx_width-1:0] preg_idx   [2*lane_count],
  input  logic [data_width-1:0]     preg_value [2*lane_count],
  output ex_lane_t                  ex         [lane_count]
);

  ex_lane_t ex_next [lane_count];

  // Zero register, then CDB lane 0, then lane 1, then the file
  function automatic logic [data_width-1:0] pick_operand(
    input logic [preg_idx_width-1:0] idx,
    input logic [data_width-1:0]     file_value,
    input cdb_lane_t                 bus [lane_count]
  );
    logic [data_width-1:0] result;
    result = file_value;
    for (int l = lane_count - 1; l >= 0; l--)
    begin
      if (bus[l].valid && (bus[l].tag == idx))
      begin
        result = bus[l].value;  // Lane 0 visited last
      end
    end
    if (idx == zero_preg)
    begin
      result = '0;
    end
    return result;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Operand read and bypass

  always_comb
  begin
    for (int l = 0; l < lane_count; l++)
    begin
      preg_idx[2*l]   = issue[l].prega;
      preg_idx[2*l+1] = issue[l].pregb;

      ex_next[l].valid    = issue[l].valid;
      ex_next[l].opa      = pick_operand(issue[l].prega, preg_value[2*l], cdb);
      ex_next[l].opb      = pick_operand(issue[l].pregb, preg_value[2*l+1], cdb);
      ex_next[l].pdest    = issue[l].pdest;
      ex_next[l].alu_func = issue[l].alu_func;
      ex_next[l].rob_idx  = issue[l].rob_idx;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue/execute register

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int l = 0; l < lane_count; l++)
      begin
        ex[l] <= '0;
      end
    end
    else if (flush)  // Mispredict recovery
    begin
      for (int l = 0; l < lane_count; l++)
      begin
        ex[l] <= '0;
      end
    end
    else
    begin
      ex <= ex_next;
    end
  end

endmodule

/* src/prf.sv */
//////////////////////////////////////////////////////////////////////
// Reads are combinational with no write-through from the CDB
// zero_preg ignores writes, and lane 1 wins a same-tag collision
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module prf
  import oo_backend_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n,
  input  cdb_lane_t                 cdb     [lane_count],
  input  logic [preg_idx_width-1:0] rd_idx  [3*lane_count],
  output logic [data_width-1:0]     rd_data [3*lane_count]
);

  logic [data_width-1:0] regs [preg_count];

  //////////////////////////////////////////////////////////////////////
  // CDB write ports

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < preg_count; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      // Higher lane applied last so it wins
      for (int l = 0; l < lane_count; l++)
      begin
        if (cdb[l].valid && (cdb[l].tag != zero_preg))
        begin
          regs[cdb[l].tag] <= cdb[l].value;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports, operands first then commit

  always_comb
  begin
    for (int i = 0; i < 3*lane_count; i++)
    begin
      rd_data[i] = regs[rd_idx[i]];  // Entry 0 never written
    end
  end

endmodule

/* src/oo_backend_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared widths and lane structs for the two-lane back end
// Built for lane_count == 2, and lane 0 is always the older instruction
//////////////////////////////////////////////////////////////////////

package oo_backend_pkg;

  localparam int lane_count     = 2;
  localparam int data_width     = 64;
  localparam int preg_count     = 64;
  localparam int preg_idx_width = 6;
  localparam int arch_idx_width = 5;
  localparam int rob_idx_width  = 5;
  localparam int alu_func_width = 5;
  localparam int ir_width       = 32;

  localparam logic [preg_idx_width-1:0] zero_preg = '0;  // Hardwired zero
  localparam logic [ir_width-1:0]       halt_inst = 32'h555;

  typedef enum logic [3:0] {
    no_error          = 4'd0,
    halted_on_halt    = 4'd1,
    halted_on_illegal = 4'd2
  } err_status_t;

  //////////////////////////////////////////////////////////////////////
  // Lane payloads

  typedef struct packed {
    logic                      valid;
    logic [preg_idx_width-1:0] tag;
    logic [data_width-1:0]     value;
  } cdb_lane_t;

  typedef struct packed {
    logic                      valid;
    logic [preg_idx_width-1:0] prega;
    logic [preg_idx_width-1:0] pregb;
    logic [preg_idx_width-1:0] pdest;
    logic [alu_func_width-1:0] alu_func;
    logic [rob_idx_width-1:0]  rob_idx;
  } issue_lane_t;

  typedef struct packed {
    logic                      valid;
    logic [data_width-1:0]     opa;
    logic [data_width-1:0]     opb;
    logic [preg_idx_width-1:0] pdest;
    logic [alu_func_width-1:0] alu_func;
    logic [rob_idx_width-1:0]  rob_idx;
  } ex_lane_t;

  typedef struct packed {
    logic                      valid;
    logic                      illegal;
    logic [ir_width-1:0]       ir;
    logic [arch_idx_width-1:0] adest;
    logic [preg_idx_width-1:0] pdest;
  } retire_lane_t;

  typedef struct packed {
    logic                      wr_en;
    logic [arch_idx_width-1:0] wr_idx;
    logic [data_width-1:0]     wr_data;
  } commit_lane_t;

endpackage
